// File: qpi_pkg.sv
// Shared widths, opcodes and state encodings, imported by every controller module
`default_nettype none

package qpi_pkg;

	// Client side widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 24;
	localparam int LEN_W  = 7;

	// Chip selects on the PHY
	localparam int N_CS = 2;

	// One 4-bit channel, one nibble per PHY clock
	localparam int NIB_W        = 4;
	localparam int NIB_PER_WORD = DATA_W / NIB_W;

	// Shifter down-counter, MSB set marks the last nibble
	localparam int SO_CNT_W = 6;

	// Fixed opcodes, same for both chips
	typedef enum logic [7:0] {
		QPI_CMD_WRITE = 8'h02,
		QPI_CMD_READ  = 8'hEB
	} qpi_cmd_e;

	// Transaction FSM
	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_CMD      = 3'd1,
		ST_WR_DATA  = 3'd2,
		ST_RD_DUMMY = 3'd3,
		ST_RD_DATA  = 3'd4,
		ST_FLUSH    = 3'd5,
		ST_PAUSE    = 3'd6
	} ctrl_state_e;

	// Output shifter direction
	typedef enum logic {
		SO_MODE_RX = 1'b0,
		SO_MODE_TX = 1'b1
	} so_mode_e;

endpackage

`default_nettype wire

// File: burst_timer.sv
// Burst word counter and chip-select pause counter used by the transaction FSM
`timescale 1ns/100ps
`default_nettype none

module burst_timer #(
	parameter int PAUSE_CLK = 3
)(
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         start_i,
	input  wire  [qpi_pkg::LEN_W-1:0]   len_i,
	input  wire                         dec_i,
	input  wire                         pause_i,
	output logic                        last_word_o,
	output logic                        pause_done_o
);

	import qpi_pkg::*;

	// Extra bit so the count can go negative
	localparam int PAUSE_W = $clog2(PAUSE_CLK + 1) + 1;
	localparam logic [PAUSE_W-1:0] PAUSE_LOAD = PAUSE_W'(PAUSE_CLK - 2);

	logic [LEN_W-1:0]   word_cnt;
	logic [PAUSE_W-1:0] pause_cnt;

	// Words left in the burst
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			word_cnt <= '0;
		else if (start_i)
			word_cnt <= len_i;
		else if (dec_i)
			word_cnt <= word_cnt - 1'b1;
	end

	assign last_word_o = (word_cnt == '0);

	// Pause length
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst || !pause_i)
			pause_cnt <= PAUSE_LOAD;
		else if (!pause_done_o)
			pause_cnt <= pause_cnt - 1'b1;
	end

	// Sign bit marks the final pause cycle
	assign pause_done_o = pause_cnt[PAUSE_W-1];

endmodule

`default_nettype wire

// File: mem_ctrl_fsm.sv
// Transaction FSM, sequences command, dummy and data phases and owns the chip selects
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_fsm #(
	parameter int DUMMY_CLK = 6
)(
	input  wire                              clk,
	input  wire                              rst,

	input  wire                              mi_valid_i,
	input  wire                              mi_rw_i,
	input  wire                              mi_addr_cs_i,

	input  wire                              ld_now_i,
	input  wire                              so_valid_i,
	input  wire                              last_word_i,
	input  wire                              pause_done_i,

	output logic                             mi_ready_o,
	output logic                             mi_wack_o,
	output logic                             mi_wlast_o,

	output logic                             tmr_start_o,
	output logic                             tmr_dec_o,

	output logic                             ld_valid_o,
	output qpi_pkg::so_mode_e                ld_mode_o,
	output logic [qpi_pkg::SO_CNT_W-1:0]     ld_cnt_o,
	output logic                             ld_src_cmd_o,

	output logic                             cap_req_o,
	output logic                             cap_last_o,

	output logic [qpi_pkg::N_CS-1:0]         phy_cs_o
);

	import qpi_pkg::*;

	// Counter preloads, counting down through -1
	localparam logic [SO_CNT_W-1:0] CNT_WORD  = SO_CNT_W'(NIB_PER_WORD - 2);
	localparam logic [SO_CNT_W-1:0] CNT_DUMMY = SO_CNT_W'(DUMMY_CLK - 2);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        rd_q;
	logic        word_ld;

	// State register and chip selects
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q  <= ST_IDLE;
			phy_cs_o <= '1;
		end
		else
		begin
			state_q <= state_d;
			case (state_q)
				ST_IDLE:
				begin
					phy_cs_o <= '1;
					if (mi_valid_i)
						phy_cs_o[mi_addr_cs_i] <= 1'b0;
				end
				ST_FLUSH:
					if (!so_valid_i)
						phy_cs_o <= '1;
				ST_PAUSE:
					phy_cs_o <= '1;
				default:
					phy_cs_o <= phy_cs_o;
			endcase
		end
	end

	// Direction of the accepted request
	always_ff @(posedge clk)
	begin
		if (mi_ready_o && mi_valid_i)
			rd_q <= mi_rw_i;
	end

	// Next state and shifter load selection
	always_comb
	begin
		state_d      = state_q;
		ld_valid_o   = 1'b0;
		ld_mode_o    = SO_MODE_RX;
		ld_cnt_o     = CNT_WORD;
		ld_src_cmd_o = 1'b0;
		word_ld      = 1'b0;

		case (state_q)
			ST_IDLE:
			begin
				// Opcode and address go out first
				ld_valid_o   = mi_valid_i;
				ld_mode_o    = SO_MODE_TX;
				ld_src_cmd_o = 1'b1;
				if (mi_valid_i)
					state_d = ST_CMD;
			end

			ST_CMD:
			begin
				ld_valid_o = 1'b1;
				if (rd_q)
				begin
					ld_cnt_o = CNT_DUMMY;
					if (ld_now_i)
						state_d = ST_RD_DUMMY;
				end
				else
				begin
					ld_mode_o = SO_MODE_TX;
					word_ld   = ld_now_i;
					if (ld_now_i)
						state_d = last_word_i ? ST_FLUSH : ST_WR_DATA;
				end
			end

			ST_WR_DATA:
			begin
				ld_valid_o = 1'b1;
				ld_mode_o  = SO_MODE_TX;
				word_ld    = ld_now_i;
				if (ld_now_i && last_word_i)
					state_d = ST_FLUSH;
			end

			// End of dummy loads the first read word
			ST_RD_DUMMY:
			begin
				ld_valid_o = 1'b1;
				word_ld    = ld_now_i;
				if (ld_now_i)
					state_d = last_word_i ? ST_FLUSH : ST_RD_DATA;
			end

			ST_RD_DATA:
			begin
				ld_valid_o = 1'b1;
				word_ld    = ld_now_i;
				if (ld_now_i && last_word_i)
					state_d = ST_FLUSH;
			end

			ST_FLUSH:
				if (!so_valid_i)
					state_d = ST_PAUSE;

			ST_PAUSE:
				if (pause_done_i)
					state_d = ST_IDLE;

			default:
				state_d = ST_IDLE;
		endcase
	end

	// Client handshake
	assign mi_ready_o  = (state_q == ST_IDLE);
	assign mi_wack_o   = word_ld & ~rd_q;
	assign mi_wlast_o  = mi_wack_o & last_word_i;

	// Burst word counting
	assign tmr_start_o = (state_q == ST_IDLE) & mi_valid_i;
	assign tmr_dec_o   = word_ld;

	// Last nibble of a read word leaves the shifter
	assign cap_req_o  = so_valid_i & ld_now_i &
		((state_q == ST_RD_DATA) | ((state_q == ST_FLUSH) & rd_q));
	assign cap_last_o = (state_q == ST_FLUSH);

endmodule

`default_nettype wire

// File: qpi_shift_out.sv
// Output shifter, drives PHY nibbles, clock and output enables one nibble per cycle
`timescale 1ns/100ps
`default_nettype none

module qpi_shift_out (
	input  wire                              clk,
	input  wire                              rst,

	// Load request from the FSM
	input  wire                              ld_valid_i,
	input  wire  qpi_pkg::so_mode_e          ld_mode_i,
	input  wire  [qpi_pkg::SO_CNT_W-1:0]     ld_cnt_i,
	input  wire                              ld_src_cmd_i,

	// Load sources
	input  wire  qpi_pkg::qpi_cmd_e          cmd_i,
	input  wire  [qpi_pkg::ADDR_W-1:0]       addr_i,
	input  wire  [qpi_pkg::DATA_W-1:0]       wdata_i,

	output logic                             ld_now_o,
	output logic                             so_valid_o,
	output logic                             so_last_o,

	// PHY
	output logic [qpi_pkg::NIB_W-1:0]        phy_io_o,
	output logic [qpi_pkg::NIB_W-1:0]        phy_io_oe_o,
	output logic                             phy_clk_o
);

	import qpi_pkg::*;

	logic [DATA_W-1:0]   sr_q;
	so_mode_e            mode_q;
	logic [SO_CNT_W-1:0] cnt_q;

	// Counter underflow flags the last nibble
	assign so_last_o = cnt_q[SO_CNT_W-1];

	// Empty, or about to be, so the next word can follow without a gap
	assign ld_now_o = ~so_valid_o | so_last_o;

	// Control
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			so_valid_o <= 1'b0;
		else
			so_valid_o <= (so_valid_o & ~so_last_o) | (ld_now_o & ld_valid_i);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mode_q <= SO_MODE_RX;
			cnt_q  <= '1;
		end
		else if (ld_now_o)
		begin
			mode_q <= ld_mode_i;
			cnt_q  <= ld_cnt_i;
		end
		else
		begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Shift register
	// --------------------

	// MSB nibble goes out first
	always_ff @(posedge clk)
	begin
		if (ld_now_o)
			sr_q <= ld_src_cmd_i ? {cmd_i, addr_i} : wdata_i;
		else
			sr_q <= {sr_q[DATA_W-NIB_W-1:0], {NIB_W{1'b0}}};
	end

	// PHY drive
	// --------------------

	assign phy_clk_o   = so_valid_o;
	assign phy_io_o    = sr_q[DATA_W-1 -: NIB_W];
	assign phy_io_oe_o = (so_valid_o && (mode_q == SO_MODE_TX)) ? {NIB_W{1'b1}} : {NIB_W{1'b0}};

endmodule

`default_nettype wire

// File: qpi_shift_in.sv
// Read path, assembles nibbles into words and aligns the strobe with the PHY delay
`timescale 1ns/100ps
`default_nettype none

module qpi_shift_in #(
	parameter int PHY_DELAY = 6
)(
	input  wire                          clk,
	input  wire                          cap_req_i,
	input  wire                          cap_last_i,
	input  wire  [qpi_pkg::NIB_W-1:0]    phy_io_i,
	output logic [qpi_pkg::DATA_W-1:0]   rdata_o,
	output logic                         rstb_o,
	output logic                         rlast_o
);

	import qpi_pkg::*;

	// One stage to register the request, then the PHY pipeline
	localparam int DLY_N = PHY_DELAY + 1;

	logic [DATA_W-1:0] sr_q;
	logic [DLY_N-1:0]  stb_q  = '0;
	logic [DLY_N-1:0]  last_q = '0;

	// Input shifter
	// --------------------

	// Earliest nibble ends up in the top of the word
	always_ff @(posedge clk)
	begin
		sr_q <= {sr_q[DATA_W-NIB_W-1:0], phy_io_i};
	end

	assign rdata_o = sr_q;

	// Strobe delay line
	// --------------------

	// Several words may be in flight at once
	always @(posedge clk)
	begin
		stb_q  <= (stb_q << 1) | DLY_N'(cap_req_i);
		last_q <= (last_q << 1) | DLY_N'(cap_req_i & cap_last_i);
	end

	assign rstb_o  = stb_q[DLY_N-1];
	assign rlast_o = last_q[DLY_N-1];

endmodule

`default_nettype wire

// File: qpi_memctrl.sv
// QPI memory controller top, wires the FSM, timers and shift units between client and PHY
`timescale 1ns/100ps
`default_nettype none

module qpi_memctrl #(
	parameter int DUMMY_CLK = 6,
	parameter int PAUSE_CLK = 3,
	parameter int PHY_DELAY = 6
)(
	input  wire                          clk,
	input  wire                          rst,

	// Client request
	input  wire                          mi_valid_i,
	input  wire                          mi_rw_i,
	input  wire                          mi_addr_cs_i,
	input  wire  [qpi_pkg::ADDR_W-1:0]   mi_addr_i,
	input  wire  [qpi_pkg::LEN_W-1:0]    mi_len_i,
	output logic                         mi_ready_o,

	// Client write data
	input  wire  [qpi_pkg::DATA_W-1:0]   mi_wdata_i,
	output logic                         mi_wack_o,
	output logic                         mi_wlast_o,

	// Client read data
	output logic [qpi_pkg::DATA_W-1:0]   mi_rdata_o,
	output logic                         mi_rstb_o,
	output logic                         mi_rlast_o,

	// PHY
	input  wire  [qpi_pkg::NIB_W-1:0]    phy_io_i,
	output logic [qpi_pkg::NIB_W-1:0]    phy_io_o,
	output logic [qpi_pkg::NIB_W-1:0]    phy_io_oe_o,
	output logic                         phy_clk_o,
	output logic [qpi_pkg::N_CS-1:0]     phy_cs_o
);

	import qpi_pkg::*;

	// Signals
	// --------------------

	logic                ld_now;
	logic                so_valid;
	logic                ld_valid;
	so_mode_e            ld_mode;
	logic [SO_CNT_W-1:0] ld_cnt;
	logic                ld_src_cmd;
	qpi_cmd_e            cmd;

	logic                tmr_start;
	logic                tmr_dec;
	logic                last_word;
	logic                pause_run;
	logic                pause_done;

	logic                cap_req;
	logic                cap_last;

	// Opcode follows the request direction
	assign cmd = mi_rw_i ? QPI_CMD_READ : QPI_CMD_WRITE;

	// Pause time runs while every chip is deselected
	assign pause_run = &phy_cs_o;

	// Control
	// --------------------

	mem_ctrl_fsm #(
		.DUMMY_CLK (DUMMY_CLK)
	) fsm_i (
		.clk          (clk),
		.rst          (rst),
		.mi_valid_i   (mi_valid_i),
		.mi_rw_i      (mi_rw_i),
		.mi_addr_cs_i (mi_addr_cs_i),
		.ld_now_i     (ld_now),
		.so_valid_i   (so_valid),
		.last_word_i  (last_word),
		.pause_done_i (pause_done),
		.mi_ready_o   (mi_ready_o),
		.mi_wack_o    (mi_wack_o),
		.mi_wlast_o   (mi_wlast_o),
		.tmr_start_o  (tmr_start),
		.tmr_dec_o    (tmr_dec),
		.ld_valid_o   (ld_valid),
		.ld_mode_o    (ld_mode),
		.ld_cnt_o     (ld_cnt),
		.ld_src_cmd_o (ld_src_cmd),
		.cap_req_o    (cap_req),
		.cap_last_o   (cap_last),
		.phy_cs_o     (phy_cs_o)
	);

	burst_timer #(
		.PAUSE_CLK (PAUSE_CLK)
	) timer_i (
		.clk          (clk),
		.rst          (rst),
		.start_i      (tmr_start),
		.len_i        (mi_len_i),
		.dec_i        (tmr_dec),
		.pause_i      (pause_run),
		.last_word_o  (last_word),
		.pause_done_o (pause_done)
	);

	// Datapath
	// --------------------

	qpi_shift_out shift_out_i (
		.clk          (clk),
		.rst          (rst),
		.ld_valid_i   (ld_valid),
		.ld_mode_i    (ld_mode),
		.ld_cnt_i     (ld_cnt),
		.ld_src_cmd_i (ld_src_cmd),
		.cmd_i        (cmd),
		.addr_i       (mi_addr_i),
		.wdata_i      (mi_wdata_i),
		.ld_now_o     (ld_now),
		.so_valid_o   (so_valid),
		.so_last_o    (),
		.phy_io_o     (phy_io_o),
		.phy_io_oe_o  (phy_io_oe_o),
		.phy_clk_o    (phy_clk_o)
	);

	qpi_shift_in #(
		.PHY_DELAY (PHY_DELAY)
	) shift_in_i (
		.clk          (clk),
		.cap_req_i    (cap_req),
		.cap_last_i   (cap_last),
		.phy_io_i     (phy_io_i),
		.rdata_o      (mi_rdata_o),
		.rstb_o       (mi_rstb_o),
		.rlast_o      (mi_rlast_o)
	);

endmodule

`default_nettype wire

// File: tb_psram_model.sv
// Behavioral QPI PSRAM for the testbench, decodes PHY traffic and returns read nibbles late
`timescale 1ns/100ps
`default_nettype none

module tb_psram_model #(
	parameter int DUMMY_CLK = 6,
	parameter int PHY_DELAY = 6
)(
	input  wire                          clk,
	input  wire  [qpi_pkg::N_CS-1:0]     cs_n_i,
	input  wire                          sck_i,
	input  wire  [qpi_pkg::NIB_W-1:0]    sio_i,
	output logic [qpi_pkg::NIB_W-1:0]    sio_o,
	output qpi_pkg::qpi_cmd_e            cmd_o,
	output logic [qpi_pkg::ADDR_W-1:0]   addr_o,
	output int                           cmd_cnt_o
);

	import qpi_pkg::*;

	// Storage covers the low 12 address bits only
	localparam int MEM_BYTES = 4096;

	logic [7:0]       mem [N_CS][MEM_BYTES];
	logic [NIB_W-1:0] ret_q [PHY_DELAY+1];
	logic [31:0]      hdr;
	logic [NIB_W-1:0] ret_nib;
	logic [11:0]      idx;
	int               nib_n;
	int               chip;
	int               m;
	int               c;
	int               i;
	int               j;

	// Power-up contents
	// --------------------

	initial
	begin
		for (c = 0; c < N_CS; c++)
			for (i = 0; i < MEM_BYTES; i++)
				mem[c][i] = 8'(i ^ (i >> 4) ^ (i >> 8)) ^ 8'(c * 8'h5a);
		for (i = 0; i <= PHY_DELAY; i++)
			ret_q[i] = '0;
		sio_o     = '0;
		hdr       = '0;
		nib_n     = 0;
		chip      = 0;
		cmd_o     = QPI_CMD_WRITE;
		addr_o    = '0;
		cmd_cnt_o = 0;
	end

	// Bus decode
	// --------------------

	// PHY outputs are registered, so they are settled shortly after the edge
	always @(posedge clk)
	begin
		#2;
		ret_nib = '0;
		if (&cs_n_i)
			nib_n = 0;
		else if (sck_i)
		begin
			chip = cs_n_i[0] ? 1 : 0;
			if (nib_n < 8)
			begin
				// Opcode then address, MSB nibble first
				hdr = {hdr[27:0], sio_i};
				if (nib_n == 7)
				begin
					cmd_o     = qpi_cmd_e'(hdr[31:24]);
					addr_o    = hdr[23:0];
					cmd_cnt_o = cmd_cnt_o + 1;
				end
			end
			else if (cmd_o == QPI_CMD_WRITE)
			begin
				m   = nib_n - 8;
				idx = 12'(addr_o + m / 2);
				if (m % 2 == 0)
					mem[chip][idx][7:4] = sio_i;
				else
					mem[chip][idx][3:0] = sio_i;
			end
			else if (nib_n >= 8 + DUMMY_CLK)
			begin
				m       = nib_n - 8 - DUMMY_CLK;
				idx     = 12'(addr_o + m / 2);
				ret_nib = (m % 2 == 0) ? mem[chip][idx][7:4] : mem[chip][idx][3:0];
			end
			nib_n = nib_n + 1;
		end

		// Nibble of this clock comes back PHY_DELAY cycles later
		for (j = PHY_DELAY; j > 0; j--)
			ret_q[j] = ret_q[j-1];
		ret_q[0] = ret_nib;
		sio_o    = ret_q[PHY_DELAY];
	end

endmodule

`default_nettype wire

// File: tb_qpi_memctrl.sv
// Testbench top that runs random write and read-back bursts through the controller into a PSRAM model
`timescale 1ns/100ps
`default_nettype none

module tb_qpi_memctrl;

	import qpi_pkg::*;

	localparam int DUMMY_CLK   = 6;
	localparam int PAUSE_CLK   = 3;
	localparam int PHY_DELAY   = 6;
	localparam int N_PAIRS     = 20;
	localparam int TIMEOUT_CYC = 2 * N_PAIRS * (PAUSE_CLK + DUMMY_CLK + 8 * 9 + 20);
	localparam int MEM_BYTES   = 4096;
	localparam logic [31:0] SEED = 32'hc1d0_9c05;

	logic              clk;
	logic              rst;
	logic              mi_valid;
	logic              mi_rw;
	logic              mi_addr_cs;
	logic [ADDR_W-1:0] mi_addr;
	logic [LEN_W-1:0]  mi_len;
	logic              mi_ready;
	logic [DATA_W-1:0] mi_wdata;
	logic              mi_wack;
	logic              mi_wlast;
	logic [DATA_W-1:0] mi_rdata;
	logic              mi_rstb;
	logic              mi_rlast;
	logic [NIB_W-1:0]  phy_io_in;
	logic [NIB_W-1:0]  phy_io_out;
	logic [NIB_W-1:0]  phy_io_oe;
	logic              phy_clk;
	logic [N_CS-1:0]   phy_cs;
	qpi_cmd_e          dec_cmd;
	logic [ADDR_W-1:0] dec_addr;
	int                dec_cnt;

	logic [31:0]       lfsr_q;
	logic [7:0]        ref_mem [N_CS][MEM_BYTES];
	logic [DATA_W-1:0] wr_words [8];
	logic [DATA_W-1:0] exp_q [$];
	logic              mon_en;
	logic              cur_rw;
	logic [N_CS-1:0]   cur_cs_n;
	int                cur_len;
	int                clk_cnt;
	int                wack_cnt;
	int                rstb_cnt;
	int                hi_run;
	logic              ready_prev;
	int                check_cnt;
	int                err_cnt;
	int                test_cnt;
	int                cycle_cnt;

	qpi_memctrl #(
		.DUMMY_CLK (DUMMY_CLK),
		.PAUSE_CLK (PAUSE_CLK),
		.PHY_DELAY (PHY_DELAY)
	) qpi_memctrl_i (
		.clk          (clk),
		.rst          (rst),
		.mi_valid_i   (mi_valid),
		.mi_rw_i      (mi_rw),
		.mi_addr_cs_i (mi_addr_cs),
		.mi_addr_i    (mi_addr),
		.mi_len_i     (mi_len),
		.mi_ready_o   (mi_ready),
		.mi_wdata_i   (mi_wdata),
		.mi_wack_o    (mi_wack),
		.mi_wlast_o   (mi_wlast),
		.mi_rdata_o   (mi_rdata),
		.mi_rstb_o    (mi_rstb),
		.mi_rlast_o   (mi_rlast),
		.phy_io_i     (phy_io_in),
		.phy_io_o     (phy_io_out),
		.phy_io_oe_o  (phy_io_oe),
		.phy_clk_o    (phy_clk),
		.phy_cs_o     (phy_cs)
	);

	tb_psram_model #(
		.DUMMY_CLK (DUMMY_CLK),
		.PHY_DELAY (PHY_DELAY)
	) psram_i (
		.clk       (clk),
		.cs_n_i    (phy_cs),
		.sck_i     (phy_clk),
		.sio_i     (phy_io_out),
		.sio_o     (phy_io_in),
		.cmd_o     (dec_cmd),
		.addr_o    (dec_addr),
		.cmd_cnt_o (dec_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
		$display("Simulation failed");
		$finish;
	end

	// Random source
	// --------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v      = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Compare tasks
	// --------------------

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(input qpi_cmd_e got, input qpi_cmd_e exp, input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		check_cnt++;
		if (got != exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_nib(input logic [NIB_W-1:0] got, input logic [NIB_W-1:0] exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_cs(input logic [N_CS-1:0] got, input logic [N_CS-1:0] exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Bus monitor
	// --------------------

	// Everything DUT-side is sampled mid-cycle
	always @(negedge clk)
	begin
		if (mon_en)
		begin
			if (mi_ready && !ready_prev && hi_run < PAUSE_CLK)
			begin
				err_cnt++;
				$display("error at %0t: chip selects were high for only %0d cycles before ready",
					$time, hi_run);
			end
			hi_run     = (&phy_cs) ? hi_run + 1 : 0;
			ready_prev = mi_ready;

			if (mi_ready)
				check_cs(phy_cs, {N_CS{1'b1}}, "idle chip selects");
			else if (phy_clk || phy_cs != {N_CS{1'b1}})
				check_cs(phy_cs, cur_cs_n, "active chip selects");

			// Only the read dummy and data clocks release the lines
			if (phy_clk)
			begin
				check_nib(phy_io_oe,
					(!cur_rw || clk_cnt < 8) ? {NIB_W{1'b1}} : {NIB_W{1'b0}}, "output enable");
				clk_cnt++;
			end

			if ((mi_wlast && !mi_wack) || (mi_rlast && !mi_rstb))
			begin
				err_cnt++;
				$display("error at %0t: a last flag was raised without its strobe", $time);
			end

			if (mi_wack)
			begin
				check_flag(mi_wlast, wack_cnt == cur_len, "write last");
				wack_cnt++;
			end

			if (mi_rstb)
			begin
				check_flag(mi_rlast, rstb_cnt == cur_len, "read last");
				if (exp_q.size() == 0)
				begin
					err_cnt++;
					$display("error at %0t: read strobe with no word outstanding", $time);
				end
				else
					check_word(mi_rdata, exp_q.pop_front(), "read data");
				rstb_cnt++;
			end
		end
	end

	// Transactions
	// --------------------

	task automatic run_txn(input logic rw, input logic chip, input logic [ADDR_W-1:0] addr,
		input int len);
		int                errs_before;
		int                cmd_before;
		int                w;
		int                b;
		logic [11:0]       idx;
		logic [DATA_W-1:0] word;
		qpi_cmd_e          exp_cmd;

		errs_before = err_cnt;
		cmd_before  = dec_cnt;

		// Big-endian bytes at ascending addresses
		for (w = 0; w <= len; w++)
		begin
			word = '0;
			for (b = 0; b < 4; b++)
			begin
				idx = 12'(addr + 4 * w + b);
				if (!rw)
					ref_mem[chip][idx] = wr_words[w][31 - 8 * b -: 8];
				word = {word[DATA_W-9:0], ref_mem[chip][idx]};
			end
			if (rw)
				exp_q.push_back(word);
		end

		cur_rw   = rw;
		cur_cs_n = ~(N_CS'(1) << chip);
		cur_len  = len;
		clk_cnt  = 0;
		wack_cnt = 0;
		rstb_cnt = 0;

		while (!mi_ready)
		begin
			@(posedge clk);
			#2;
		end
		mi_valid   = 1'b1;
		mi_rw      = rw;
		mi_addr_cs = chip;
		mi_addr    = addr;
		mi_len     = LEN_W'(len);
		mi_wdata   = wr_words[0];
		@(posedge clk);
		#2;
		mi_valid = 1'b0;

		// Next write word follows each ack
		while (!mi_ready || (rw && rstb_cnt <= len))
		begin
			mi_wdata = wr_words[(wack_cnt > len) ? len : wack_cnt];
			@(posedge clk);
			#2;
		end

		exp_cmd = rw ? QPI_CMD_READ : QPI_CMD_WRITE;
		check_count(clk_cnt, 8 + 8 * (len + 1) + (rw ? DUMMY_CLK : 0), "PHY clock cycles");
		check_count(rstb_cnt, rw ? len + 1 : 0, "read strobes");
		check_count(wack_cnt, rw ? 0 : len + 1, "write acks");
		check_count(dec_cnt, cmd_before + 1, "decoded commands");
		check_cmd(dec_cmd, exp_cmd, "opcode");
		check_addr(dec_addr, addr, "address");

		test_cnt++;
		$display("test %0d: %s chip %0d addr %06h words %0d, %0d errors", test_cnt,
			rw ? "read " : "write", chip, addr, len + 1, err_cnt - errs_before);
	endtask

	initial
	begin : main_seq
		logic [31:0]       r;
		logic              chip;
		logic [ADDR_W-1:0] addr;
		int                wlen;
		int                rlen;
		int                p;
		int                w;

		rst        = 1'b1;
		mi_valid   = 1'b0;
		mi_rw      = 1'b0;
		mi_addr_cs = 1'b0;
		mi_addr    = '0;
		mi_len     = '0;
		mi_wdata   = '0;
		mon_en     = 1'b0;
		cur_rw     = 1'b0;
		cur_cs_n   = '1;
		cur_len    = 0;
		clk_cnt    = 0;
		wack_cnt   = 0;
		rstb_cnt   = 0;
		hi_run     = 0;
		ready_prev = 1'b1;
		check_cnt  = 0;
		err_cnt    = 0;
		test_cnt   = 0;
		lfsr_q     = SEED;

		repeat (2) @(posedge clk);
		#2;
		rst    = 1'b0;
		mon_en = 1'b1;

		// Each write is read back from the same start with an equal or shorter length
		for (p = 0; p < N_PAIRS; p++)
		begin
			rand_bits(1, r);
			chip = r[0];
			rand_bits(ADDR_W - 2, r);
			addr = {r[ADDR_W-3:0], 2'b00};
			rand_bits(3, r);
			wlen = int'(r[2:0]);
			for (w = 0; w < 8; w++)
			begin
				rand_bits(DATA_W, r);
				wr_words[w] = r;
			end
			run_txn(1'b0, chip, addr, wlen);
			rand_bits(3, r);
			rlen = int'(r[2:0]) % (wlen + 1);
			run_txn(1'b1, chip, addr, rlen);
		end

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
qpi_pkg.sv
burst_timer.sv
mem_ctrl_fsm.sv
qpi_shift_out.sv
qpi_shift_in.sv
qpi_memctrl.sv
tb_psram_model.sv
tb_qpi_memctrl.sv
